// ==== rtl/dsp_pkg.sv ====
package dsp_pkg;

    localparam int DATA_SIZE   = 32;
    localparam int DATA_SIZE_2 = 64;                 // Products and sums.
    localparam int QUANT_BITS  = 10;

    localparam int FIR_NUM_TAPS   = 8;
    localparam int FIR_DECIMATION = 2;
    localparam int FIFO_DEPTH     = 16;

    // Symmetric low-pass shape, sums to one in Q10.
    localparam logic signed [DATA_SIZE-1:0] COEFFS_REAL [FIR_NUM_TAPS] = '{
        -32'sd16,
        32'sd40,
        32'sd152,
        32'sd336,
        32'sd336,
        32'sd152,
        32'sd40,
        -32'sd16
    };

    localparam logic signed [DATA_SIZE-1:0] COEFFS_IMAG [FIR_NUM_TAPS] = '{
        32'sd8,
        -32'sd24,
        32'sd56,
        32'sd120,
        -32'sd120,
        -32'sd56,
        32'sd24,
        -32'sd8
    };

    typedef enum logic [1:0] {
        FIR_LOAD,                                    // Shift in samples.
        FIR_MAC,                                     // One tap per cycle.
        FIR_WRITE                                    // Push result pair.
    } fir_state_t;

    // Full width signed product, no rounding.
    function automatic logic signed [DATA_SIZE_2-1:0] multiply(
        input logic signed [DATA_SIZE-1:0] a,
        input logic signed [DATA_SIZE-1:0] b
    );
        return DATA_SIZE_2'(a) * DATA_SIZE_2'(b);
    endfunction

    function automatic logic signed [DATA_SIZE_2-1:0] dequantize(
        input logic signed [DATA_SIZE_2-1:0] value
    );
        return value >>> QUANT_BITS;                 // Arithmetic shift keeps sign.
    endfunction

endpackage

// ==== rtl/fifo.sv ====
module fifo #(
    parameter int WIDTH = dsp_pkg::DATA_SIZE,
    parameter int DEPTH = dsp_pkg::FIFO_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] count_next;
    logic               do_write;
    logic               do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;
    assign dout     = mem[rd_ptr];                   // Head word, first-word fall-through.

    always_comb begin
        count_next = count;
        if (do_write && !do_read) begin
            count_next = count + 1'b1;
        end else if (do_read && !do_write) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == COUNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== rtl/fir_cmplx.sv ====
module fir_cmplx #(
    parameter int NUM_TAPS   = dsp_pkg::FIR_NUM_TAPS,
    parameter int DECIMATION = dsp_pkg::FIR_DECIMATION
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [dsp_pkg::DATA_SIZE-1:0] xreal_in_dout,
    input  logic                          xreal_in_empty,
    output logic                          xreal_in_rd_en,
    input  logic [dsp_pkg::DATA_SIZE-1:0] ximag_in_dout,
    input  logic                          ximag_in_empty,
    output logic                          ximag_in_rd_en,
    output logic                          yreal_out_wr_en,
    input  logic                          yreal_out_full,
    output logic [dsp_pkg::DATA_SIZE-1:0] yreal_out_din,
    output logic                          yimag_out_wr_en,
    input  logic                          yimag_out_full,
    output logic [dsp_pkg::DATA_SIZE-1:0] yimag_out_din
);

    localparam int DEC_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
    localparam int TAP_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

    dsp_pkg::fir_state_t state;

    // Index 0 holds the newest sample.
    logic signed [dsp_pkg::DATA_SIZE-1:0]   xreal_line [NUM_TAPS];
    logic signed [dsp_pkg::DATA_SIZE-1:0]   ximag_line [NUM_TAPS];
    logic [DEC_W-1:0]                       dec_count;
    logic [TAP_W-1:0]                       tap_count;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] yreal_acc;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] yimag_acc;

    logic                                   take_sample;
    logic                                   write_out;
    logic                                   last_sample;
    logic                                   last_tap;
    logic signed [dsp_pkg::DATA_SIZE-1:0]   tap_xr;
    logic signed [dsp_pkg::DATA_SIZE-1:0]   tap_xi;
    logic signed [dsp_pkg::DATA_SIZE-1:0]   tap_cr;
    logic signed [dsp_pkg::DATA_SIZE-1:0]   tap_ci;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] prod_rr;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] prod_ii;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] prod_ri;
    logic signed [dsp_pkg::DATA_SIZE_2-1:0] prod_ir;

    assign take_sample = (state == dsp_pkg::FIR_LOAD) && !xreal_in_empty && !ximag_in_empty;
    assign write_out   = (state == dsp_pkg::FIR_WRITE) && !yreal_out_full && !yimag_out_full;
    assign last_sample = (dec_count == DEC_W'(DECIMATION - 1));
    assign last_tap    = (tap_count == TAP_W'(NUM_TAPS - 1));

    assign xreal_in_rd_en = take_sample;             // Both lanes pop together.
    assign ximag_in_rd_en = take_sample;

    assign tap_xr = xreal_line[tap_count];
    assign tap_xi = ximag_line[tap_count];
    assign tap_cr = dsp_pkg::COEFFS_REAL[tap_count];
    assign tap_ci = dsp_pkg::COEFFS_IMAG[tap_count];

    assign prod_rr = dsp_pkg::multiply(tap_xr, tap_cr);
    assign prod_ii = dsp_pkg::multiply(tap_xi, tap_ci);
    assign prod_ri = dsp_pkg::multiply(tap_xr, tap_ci);
    assign prod_ir = dsp_pkg::multiply(tap_xi, tap_cr);

    assign yreal_out_wr_en = write_out;
    assign yimag_out_wr_en = write_out;
    assign yreal_out_din   = yreal_acc[dsp_pkg::DATA_SIZE-1:0];   // Wraps, no saturation.
    assign yimag_out_din   = yimag_acc[dsp_pkg::DATA_SIZE-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= dsp_pkg::FIR_LOAD;
            dec_count <= '0;
            tap_count <= '0;
            yreal_acc <= '0;
            yimag_acc <= '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                xreal_line[i] <= '0;
                ximag_line[i] <= '0;
            end
        end else begin
            case (state)
                dsp_pkg::FIR_LOAD: begin
                    if (take_sample) begin
                        for (int i = NUM_TAPS - 1; i > 0; i--) begin
                            xreal_line[i] <= xreal_line[i-1];
                            ximag_line[i] <= ximag_line[i-1];
                        end
                        xreal_line[0] <= xreal_in_dout;
                        ximag_line[0] <= ximag_in_dout;
                        dec_count     <= dec_count + 1'b1;
                        if (last_sample) begin
                            state <= dsp_pkg::FIR_MAC;
                        end
                    end
                end

                dsp_pkg::FIR_MAC: begin
                    // True complex product, imag part adds.
                    yreal_acc <= yreal_acc + dsp_pkg::dequantize(prod_rr - prod_ii);
                    yimag_acc <= yimag_acc + dsp_pkg::dequantize(prod_ri + prod_ir);
                    if (last_tap) begin
                        tap_count <= '0;
                        state     <= dsp_pkg::FIR_WRITE;
                    end else begin
                        tap_count <= tap_count + 1'b1;
                    end
                end

                dsp_pkg::FIR_WRITE: begin
                    if (write_out) begin
                        yreal_acc <= '0;
                        yimag_acc <= '0;
                        dec_count <= '0;
                        state     <= dsp_pkg::FIR_LOAD;
                    end
                end

                default: begin
                    state <= dsp_pkg::FIR_LOAD;
                end
            endcase
        end
    end

endmodule

// ==== rtl/fir_cmplx_top.sv ====
module fir_cmplx_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          xreal_wr_en,
    input  logic [dsp_pkg::DATA_SIZE-1:0] xreal_in,
    output logic                          xreal_full,
    input  logic                          ximag_wr_en,
    input  logic [dsp_pkg::DATA_SIZE-1:0] ximag_in,
    output logic                          ximag_full,
    input  logic                          yreal_rd_en,
    output logic [dsp_pkg::DATA_SIZE-1:0] yreal_out,
    output logic                          yreal_empty,
    input  logic                          yimag_rd_en,
    output logic [dsp_pkg::DATA_SIZE-1:0] yimag_out,
    output logic                          yimag_empty
);

    logic [dsp_pkg::DATA_SIZE-1:0] xreal_dout;
    logic                          xreal_empty;
    logic                          xreal_rd_en;
    logic [dsp_pkg::DATA_SIZE-1:0] ximag_dout;
    logic                          ximag_empty;
    logic                          ximag_rd_en;
    logic [dsp_pkg::DATA_SIZE-1:0] yreal_din;
    logic                          yreal_full;
    logic                          yreal_wr_en;
    logic [dsp_pkg::DATA_SIZE-1:0] yimag_din;
    logic                          yimag_full;
    logic                          yimag_wr_en;

    fifo fifo_xreal (
        .clock (clock),
        .reset (reset),
        .wr_en (xreal_wr_en),
        .din   (xreal_in),
        .full  (xreal_full),
        .rd_en (xreal_rd_en),
        .dout  (xreal_dout),
        .empty (xreal_empty)
    );

    fifo fifo_ximag (
        .clock (clock),
        .reset (reset),
        .wr_en (ximag_wr_en),
        .din   (ximag_in),
        .full  (ximag_full),
        .rd_en (ximag_rd_en),
        .dout  (ximag_dout),
        .empty (ximag_empty)
    );

    fir_cmplx fir_inst (
        .clock           (clock),
        .reset           (reset),
        .xreal_in_dout   (xreal_dout),
        .xreal_in_empty  (xreal_empty),
        .xreal_in_rd_en  (xreal_rd_en),
        .ximag_in_dout   (ximag_dout),
        .ximag_in_empty  (ximag_empty),
        .ximag_in_rd_en  (ximag_rd_en),
        .yreal_out_wr_en (yreal_wr_en),
        .yreal_out_full  (yreal_full),
        .yreal_out_din   (yreal_din),
        .yimag_out_wr_en (yimag_wr_en),
        .yimag_out_full  (yimag_full),
        .yimag_out_din   (yimag_din)
    );

    fifo fifo_yreal (
        .clock (clock),
        .reset (reset),
        .wr_en (yreal_wr_en),
        .din   (yreal_din),
        .full  (yreal_full),
        .rd_en (yreal_rd_en),
        .dout  (yreal_out),
        .empty (yreal_empty)
    );

    fifo fifo_yimag (
        .clock (clock),
        .reset (reset),
        .wr_en (yimag_wr_en),
        .din   (yimag_din),
        .full  (yimag_full),
        .rd_en (yimag_rd_en),
        .dout  (yimag_out),
        .empty (yimag_empty)
    );

endmodule

// ==== verification/fir_cmplx_properties.sv ====
module fir_cmplx_properties (
    input logic clock,
    input logic reset,
    input logic xreal_in_empty,
    input logic xreal_in_rd_en,
    input logic ximag_in_empty,
    input logic ximag_in_rd_en,
    input logic yreal_out_full,
    input logic yreal_out_wr_en,
    input logic yimag_out_full,
    input logic yimag_out_wr_en
);

    timeunit 1ns;
    timeprecision 1ps;

    rd_real_not_empty: assert property (@(posedge clock) disable iff (reset)
        xreal_in_rd_en |-> !xreal_in_empty) else $error("xreal read while empty");

    rd_imag_not_empty: assert property (@(posedge clock) disable iff (reset)
        ximag_in_rd_en |-> !ximag_in_empty) else $error("ximag read while empty");

    wr_real_not_full: assert property (@(posedge clock) disable iff (reset)
        yreal_out_wr_en |-> !yreal_out_full) else $error("yreal write while full");

    wr_imag_not_full: assert property (@(posedge clock) disable iff (reset)
        yimag_out_wr_en |-> !yimag_out_full) else $error("yimag write while full");

    // Lanes move together.
    rd_en_equal: assert property (@(posedge clock) disable iff (reset)
        xreal_in_rd_en == ximag_in_rd_en) else $error("read enables differ");

    wr_en_equal: assert property (@(posedge clock) disable iff (reset)
        yreal_out_wr_en == yimag_out_wr_en) else $error("write enables differ");

endmodule

bind fir_cmplx fir_cmplx_properties i_fir_cmplx_properties (
    .clock           (clock),
    .reset           (reset),
    .xreal_in_empty  (xreal_in_empty),
    .xreal_in_rd_en  (xreal_in_rd_en),
    .ximag_in_empty  (ximag_in_empty),
    .ximag_in_rd_en  (ximag_in_rd_en),
    .yreal_out_full  (yreal_out_full),
    .yreal_out_wr_en (yreal_out_wr_en),
    .yimag_out_full  (yimag_out_full),
    .yimag_out_wr_en (yimag_out_wr_en)
);

// ==== verification/fir_cmplx_tb.sv ====
module fir_cmplx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT   = 2000;                  // Cycles per wait loop.
    localparam int BP_LIMIT     = 200;                   // Samples sent while outputs held.
    localparam int RANDOM_COUNT = 200;
    localparam int IMPULSE_LEN  = 16;

    logic                          clock;
    logic                          reset;
    logic                          xreal_wr_en;
    logic [dsp_pkg::DATA_SIZE-1:0] xreal_in;
    logic                          xreal_full;
    logic                          ximag_wr_en;
    logic [dsp_pkg::DATA_SIZE-1:0] ximag_in;
    logic                          ximag_full;
    logic                          yreal_rd_en;
    logic [dsp_pkg::DATA_SIZE-1:0] yreal_out;
    logic                          yreal_empty;
    logic                          yimag_rd_en;
    logic [dsp_pkg::DATA_SIZE-1:0] yimag_out;
    logic                          yimag_empty;

    logic                                 hold_outputs;
    logic signed [dsp_pkg::DATA_SIZE-1:0] hist_real [$];
    logic signed [dsp_pkg::DATA_SIZE-1:0] hist_imag [$];
    logic [dsp_pkg::DATA_SIZE-1:0]        exp_real [$];
    logic [dsp_pkg::DATA_SIZE-1:0]        exp_imag [$];
    int                                   check_count;
    int                                   mismatch_count;
    int                                   other_errors;
    int                                   bp_sent;

    fir_cmplx_top i_fir_cmplx_top (
        .clock       (clock),
        .reset       (reset),
        .xreal_wr_en (xreal_wr_en),
        .xreal_in    (xreal_in),
        .xreal_full  (xreal_full),
        .ximag_wr_en (ximag_wr_en),
        .ximag_in    (ximag_in),
        .ximag_full  (ximag_full),
        .yreal_rd_en (yreal_rd_en),
        .yreal_out   (yreal_out),
        .yreal_empty (yreal_empty),
        .yimag_rd_en (yimag_rd_en),
        .yimag_out   (yimag_out),
        .yimag_empty (yimag_empty)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;                      // 100 ns period.
    end

    // Complex FIR over the whole history with the newest sample at tap 0.
    function automatic void fir_model(
        input  logic signed [dsp_pkg::DATA_SIZE-1:0] xr_hist [$],
        input  logic signed [dsp_pkg::DATA_SIZE-1:0] xi_hist [$],
        output logic [dsp_pkg::DATA_SIZE-1:0]        yr,
        output logic [dsp_pkg::DATA_SIZE-1:0]        yi
    );
        longint acc_r;
        longint acc_i;
        longint xr;
        longint xi;
        longint cr;
        longint ci;
        int     n;
        acc_r = 0;
        acc_i = 0;
        n     = xr_hist.size();
        for (int k = 0; k < dsp_pkg::FIR_NUM_TAPS; k++) begin
            if (k < n) begin
                xr = longint'(xr_hist[n-1-k]);
                xi = longint'(xi_hist[n-1-k]);
            end else begin
                xr = 0;                                  // Tap line starts at zero.
                xi = 0;
            end
            cr = longint'(dsp_pkg::COEFFS_REAL[k]);
            ci = longint'(dsp_pkg::COEFFS_IMAG[k]);
            acc_r += (xr * cr - xi * ci) >>> dsp_pkg::QUANT_BITS;
            acc_i += (xr * ci + xi * cr) >>> dsp_pkg::QUANT_BITS;
        end
        yr = acc_r[dsp_pkg::DATA_SIZE-1:0];              // Wraps like the datapath.
        yi = acc_i[dsp_pkg::DATA_SIZE-1:0];
    endfunction

    function automatic logic signed [dsp_pkg::DATA_SIZE-1:0] small_random();
        return $signed($urandom_range(4095)) - 2048;
    endfunction

    task automatic check_value(
        input string                         name,
        input logic [dsp_pkg::DATA_SIZE-1:0] actual,
        input logic [dsp_pkg::DATA_SIZE-1:0] expected
    );
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Starts on a rising edge and returns one idle edge after the write.
    task automatic send_sample(
        input logic signed [dsp_pkg::DATA_SIZE-1:0] xr,
        input logic signed [dsp_pkg::DATA_SIZE-1:0] xi
    );
        int                            wait_cycles;
        logic [dsp_pkg::DATA_SIZE-1:0] yr;
        logic [dsp_pkg::DATA_SIZE-1:0] yi;
        wait_cycles = 0;
        while ((xreal_full || ximag_full) && wait_cycles < WAIT_LIMIT) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (xreal_full || ximag_full) begin
            other_errors++;
            $display("Error: input FIFOs stayed full, sample was not sent");
            return;
        end
        xreal_wr_en <= 1'b1;
        ximag_wr_en <= 1'b1;
        xreal_in    <= xr;
        ximag_in    <= xi;
        @(posedge clock);                                // Write edge.
        xreal_wr_en <= 1'b0;
        ximag_wr_en <= 1'b0;
        hist_real.push_back(xr);
        hist_imag.push_back(xi);
        if (hist_real.size() % dsp_pkg::FIR_DECIMATION == 0) begin
            fir_model(hist_real, hist_imag, yr, yi);
            exp_real.push_back(yr);
            exp_imag.push_back(yi);
        end
        @(posedge clock);                                // Full flags now include the write.
    endtask

    // Waits until every expected output pair has been read.
    task automatic wait_for_drain();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_real.size() != 0 && wait_cycles < WAIT_LIMIT) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (exp_real.size() != 0) begin
            other_errors++;
            $display("Error: %0d expected outputs never arrived", exp_real.size());
        end
    endtask

    // A read pulse is followed by one idle cycle so empty is current.
    initial begin
        yreal_rd_en <= 1'b0;
        yimag_rd_en <= 1'b0;
        forever begin
            @(posedge clock);
            if (reset) begin
                yreal_rd_en <= 1'b0;
                yimag_rd_en <= 1'b0;
            end else if (yreal_rd_en) begin
                if (exp_real.size() == 0) begin
                    other_errors++;
                    $display("Error: output pair arrived with no expected value");
                end else begin
                    check_value("yreal_out", yreal_out, exp_real.pop_front());
                    check_value("yimag_out", yimag_out, exp_imag.pop_front());
                end
                yreal_rd_en <= 1'b0;
                yimag_rd_en <= 1'b0;
            end else if (!hold_outputs && !yreal_empty && !yimag_empty) begin
                yreal_rd_en <= 1'b1;
                yimag_rd_en <= 1'b1;
            end
        end
    end

    initial begin
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        void'($urandom(32'he4cb));
        reset        <= 1'b1;
        xreal_wr_en  <= 1'b0;
        ximag_wr_en  <= 1'b0;
        xreal_in     <= '0;
        ximag_in     <= '0;
        hold_outputs <= 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        check_value("xreal_full", 32'(xreal_full), 32'd0);
        check_value("ximag_full", 32'(ximag_full), 32'd0);
        check_value("yreal_empty", 32'(yreal_empty), 32'd1);
        check_value("yimag_empty", 32'(yimag_empty), 32'd1);

        send_sample(32'sd1 <<< dsp_pkg::QUANT_BITS, 32'sd0);    // Real impulse.
        repeat (IMPULSE_LEN - 1) send_sample(32'sd0, 32'sd0);
        send_sample(32'sd0, 32'sd1 <<< dsp_pkg::QUANT_BITS);    // Imaginary impulse.
        repeat (IMPULSE_LEN - 1) send_sample(32'sd0, 32'sd0);

        repeat (RANDOM_COUNT) send_sample(small_random(), small_random());
        wait_for_drain();

        // Outputs held while inputs come slower than the filter runs.
        hold_outputs <= 1'b1;
        bp_sent = 0;
        while (!xreal_full && bp_sent < BP_LIMIT) begin
            send_sample(small_random(), small_random());
            repeat (dsp_pkg::FIR_NUM_TAPS) @(posedge clock);
            bp_sent++;
        end
        if (!xreal_full) begin
            other_errors++;
            $display("Error: xreal_full never rose while outputs were held");
        end
        hold_outputs <= 1'b0;
        while (hist_real.size() % dsp_pkg::FIR_DECIMATION != 0) begin
            send_sample(small_random(), small_random());
        end

        wait_for_drain();
        repeat (4 * dsp_pkg::FIR_NUM_TAPS) @(posedge clock);  // Room for a stray output.
        check_value("yreal_empty", 32'(yreal_empty), 32'd1);
        check_value("yimag_empty", 32'(yimag_empty), 32'd1);

        $display("Checks: %0d  mismatches: %0d  other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/dsp_pkg.sv
rtl/fifo.sv
rtl/fir_cmplx.sv
rtl/fir_cmplx_top.sv
verification/fir_cmplx_properties.sv
verification/fir_cmplx_tb.sv

// ==== Makefile ====
# Verilator build and run for the complex FIR testbench.

VERILATOR ?= verilator
TOP       ?= fir_cmplx_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
